//--- hdl/graph_config.svh
`ifndef GRAPH_CONFIG_SVH
`define GRAPH_CONFIG_SVH

// screen geometry
`define GRAPH_LINES      480
`define GRID_PITCH       40
`define GRID_COUNT       11

// plot window, inclusive horizontal limits
`define WIN_H_FIRST      33
`define WIN_H_LAST       800

// label block at the left edge
`define LABEL_ROWS       12
`define LABEL_COLS       4
`define LABEL_BAND_OFS   16   // band starts this far above the reference line
`define LABEL_BAND_LINES 14   // 7 glyph scanlines, each drawn twice

// font cell
`define GLYPH_W          6
`define GLYPH_H          7

`endif

//--- hdl/graph_pkg.sv
`default_nettype none

package graph_pkg;

    typedef logic [9:0] hpos_t;
    typedef logic [8:0] vpos_t;
    typedef logic [3:0] char_code_t;   // 0..9 digits, 15 blank
    typedef logic [5:0] glyph_row_t;   // msb is the leftmost pixel
    typedef logic [2:0] scan_t;
    typedef logic [3:0] label_row_t;
    typedef logic [1:0] label_col_t;

    typedef struct packed {
        hpos_t h;
        vpos_t v;
    } pos_s;

    // where a position lands inside the label block
    typedef struct packed {
        logic       hit;
        label_row_t row;
        label_col_t col;
        scan_t      scan;
        scan_t      px;
    } label_loc_s;

    typedef struct packed {
        logic active;
        logic on;
    } pix_s;

endpackage

`default_nettype wire

//--- hdl/label_locator.sv
`default_nettype none
`timescale 1ns/10ps
`include "graph_config.svh"

module label_locator
    import graph_pkg::*;
(
    input  logic       CK,
    input  logic       rst_n,
    input  logic       advance,
    input  pos_s       pos,
    output label_loc_s loc
);

    // first line of row 0's band
    localparam int FIRST_BAND = `GRAPH_LINES - `GRID_PITCH * `GRID_COUNT - `LABEL_BAND_OFS;
    localparam int TEXT_W     = `GLYPH_W * `LABEL_COLS;   // in halved pixels

    logic       band_hit;
    label_row_t band_row;
    scan_t      band_scan;
    logic [8:0] x;
    logic [4:0] xs;
    logic       col_hit;

    logic       hit_q;
    label_row_t row_q;
    label_col_t col_q;
    scan_t      scan_q;
    scan_t      px_q;

    // bands are 14 lines each, one every grid pitch
    always_comb begin
        int offs;
        band_hit  = 1'b0;
        band_row  = '0;
        band_scan = '0;
        for (int r = 0; r < `LABEL_ROWS; r++) begin
            offs = int'(pos.v) - FIRST_BAND - `GRID_PITCH * r;
            if (offs >= 0 && offs < `LABEL_BAND_LINES) begin
                band_hit  = 1'b1;
                band_row  = label_row_t'(r);
                band_scan = scan_t'(offs / 2);   // double height
            end
        end
    end

    assign x       = pos.h[9:1];   // double width
    assign col_hit = x < 9'(TEXT_W);
    assign xs      = x[4:0];

    always_ff @(posedge CK) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else if (advance) begin
            hit_q <= band_hit && col_hit;
        end
    end

    always_ff @(posedge CK) begin
        if (advance) begin
            row_q  <= band_row;
            scan_q <= band_scan;
            col_q  <= label_col_t'(xs / 5'(`GLYPH_W));
            px_q   <= scan_t'(xs % 5'(`GLYPH_W));
        end
    end

    assign loc = '{hit: hit_q, row: row_q, col: col_q, scan: scan_q, px: px_q};

endmodule

`default_nettype wire

//--- hdl/label_text.sv
`default_nettype none
`timescale 1ns/10ps
`include "graph_config.svh"

module label_text
    import graph_pkg::*;
(
    input  logic       CK,
    input  logic       rst_n,
    input  logic       advance,
    input  label_loc_s loc,
    output logic       label_on
);

    localparam char_code_t CHAR_SPACE = 4'hf;
    localparam scan_t      LAST_PX    = scan_t'(`GLYPH_W - 1);

    // four characters per row with the leftmost in the top nibble
    function automatic logic [4*`LABEL_COLS-1:0] label_string(label_row_t row);
        case (row)
            4'd0:    label_string = {4'h2, 4'h2, 4'h0, 4'h0};
            4'd1:    label_string = {4'h2, 4'h0, 4'h0, 4'h0};
            4'd2:    label_string = {4'h1, 4'h8, 4'h0, 4'h0};
            4'd3:    label_string = {4'h1, 4'h6, 4'h0, 4'h0};
            4'd4:    label_string = {4'h1, 4'h4, 4'h0, 4'h0};
            4'd5:    label_string = {4'h1, 4'h2, 4'h0, 4'h0};
            4'd6:    label_string = {4'h1, 4'h0, 4'h0, 4'h0};
            4'd7:    label_string = {CHAR_SPACE, 4'h8, 4'h0, 4'h0};
            4'd8:    label_string = {CHAR_SPACE, 4'h6, 4'h0, 4'h0};
            4'd9:    label_string = {CHAR_SPACE, 4'h4, 4'h0, 4'h0};
            4'd10:   label_string = {CHAR_SPACE, 4'h2, 4'h0, 4'h0};
            4'd11:   label_string = {CHAR_SPACE, CHAR_SPACE, CHAR_SPACE, 4'h0};
            default: label_string = {`LABEL_COLS{CHAR_SPACE}};
        endcase
    endfunction

    // digit font with scanline 0 in the top six bits
    function automatic glyph_row_t font_row(char_code_t code, scan_t scan);
        logic [`GLYPH_W*`GLYPH_H-1:0] bits;
        case (code)
            4'd0: bits = {6'b001110, 6'b010001, 6'b010011, 6'b010101,
                          6'b011001, 6'b010001, 6'b001110};
            4'd1: bits = {6'b000100, 6'b001100, 6'b000100, 6'b000100,
                          6'b000100, 6'b000100, 6'b001110};
            4'd2: bits = {6'b001110, 6'b010001, 6'b000001, 6'b000010,
                          6'b000100, 6'b001000, 6'b011111};
            4'd3: bits = {6'b001110, 6'b010001, 6'b000001, 6'b000110,
                          6'b000001, 6'b011001, 6'b001111};
            4'd4: bits = {6'b000010, 6'b000110, 6'b001010, 6'b010010,
                          6'b011111, 6'b000010, 6'b000010};
            4'd5: bits = {6'b011111, 6'b010000, 6'b010000, 6'b011110,
                          6'b000001, 6'b000001, 6'b011110};
            4'd6: bits = {6'b000011, 6'b000100, 6'b001000, 6'b011110,
                          6'b010001, 6'b010001, 6'b001110};
            4'd7: bits = {6'b011111, 6'b010001, 6'b000001, 6'b000010,
                          6'b000100, 6'b001000, 6'b010000};
            4'd8: bits = {6'b001110, 6'b010001, 6'b010001, 6'b011110,
                          6'b010001, 6'b010001, 6'b001110};
            4'd9: bits = {6'b001110, 6'b010001, 6'b010001, 6'b001111,
                          6'b000010, 6'b000100, 6'b011000};
            default: bits = '0;   // blank
        endcase
        font_row = bits[(`GLYPH_H - 1 - int'(scan)) * `GLYPH_W +: `GLYPH_W];
    endfunction

    logic [4*`LABEL_COLS-1:0] text;
    char_code_t               code_d;

    logic       hit2_q;
    char_code_t code2_q;
    scan_t      scan2_q;
    scan_t      px2_q;
    glyph_row_t glyph;

    assign text   = label_string(loc.row);
    assign code_d = text[(`LABEL_COLS - 1 - int'(loc.col)) * 4 +: 4];

    // stage 2 character lookup
    always_ff @(posedge CK) begin
        if (!rst_n) begin
            hit2_q <= 1'b0;
        end else if (advance) begin
            hit2_q <= loc.hit;
        end
    end

    always_ff @(posedge CK) begin
        if (advance) begin
            code2_q <= code_d;
            scan2_q <= loc.scan;
            px2_q   <= loc.px;
        end
    end

    // stage 3 font read and pixel pick
    assign glyph = font_row(code2_q, scan2_q);

    always_ff @(posedge CK) begin
        if (!rst_n) begin
            label_on <= 1'b0;
        end else if (advance) begin
            label_on <= hit2_q && glyph[LAST_PX - px2_q];
        end
    end

endmodule

`default_nettype wire

//--- hdl/grid_ruler.sv
`default_nettype none
`timescale 1ns/10ps
`include "graph_config.svh"

module grid_ruler
    import graph_pkg::*;
(
    input  logic CK,
    input  logic rst_n,
    input  logic advance,
    input  pos_s pos,
    output logic grid_on,
    output logic active
);

    logic on_line;
    pix_s s1_d;
    pix_s s1_q;
    pix_s s2_q;
    pix_s s3_q;

    always_comb begin
        on_line = pos.v == vpos_t'(`GRAPH_LINES - 1);   // bottom edge line
        for (int k = 1; k <= `GRID_COUNT; k++) begin
            if (int'(pos.v) == `GRAPH_LINES - `GRID_PITCH * k) begin
                on_line = 1'b1;
            end
        end
    end

    assign s1_d.active = pos.v < vpos_t'(`GRAPH_LINES)
                      && pos.h >= hpos_t'(`WIN_H_FIRST)
                      && pos.h <= hpos_t'(`WIN_H_LAST);
    assign s1_d.on     = on_line && pos.h[2];   // dotted, 4 on 4 off

    // two extra stages to line up with the label path
    always_ff @(posedge CK) begin
        if (!rst_n) begin
            s1_q <= '0;
            s2_q <= '0;
            s3_q <= '0;
        end else if (advance) begin
            s1_q <= s1_d;
            s2_q <= s1_q;
            s3_q <= s2_q;
        end
    end

    assign grid_on = s3_q.on;
    assign active  = s3_q.active;

endmodule

`default_nettype wire

//--- hdl/graph_overlay.sv
`default_nettype none
`timescale 1ns/10ps

module graph_overlay
    import graph_pkg::*;
(
    input  logic CK,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  pos_s in_pos,
    output logic out_valid,
    input  logic out_ready,
    output pix_s out_pix
);

    logic       advance;
    logic [2:0] vld_q;   // bit 0 is stage 1
    label_loc_s loc;
    logic       label_on;
    logic       grid_on;
    logic       win_active;

    // whole pipe moves as one, or holds
    assign advance   = !vld_q[2] || out_ready;
    assign in_ready  = advance;
    assign out_valid = vld_q[2];

    always_ff @(posedge CK) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q <= {vld_q[1:0], in_valid};
        end
    end

    label_locator u_label_locator (
        .CK      (CK),
        .rst_n   (rst_n),
        .advance (advance),
        .pos     (in_pos),
        .loc     (loc)
    );

    label_text u_label_text (
        .CK       (CK),
        .rst_n    (rst_n),
        .advance  (advance),
        .loc      (loc),
        .label_on (label_on)
    );

    grid_ruler u_grid_ruler (
        .CK      (CK),
        .rst_n   (rst_n),
        .advance (advance),
        .pos     (in_pos),
        .grid_on (grid_on),
        .active  (win_active)
    );

    // stage 3 registers of both paths meet here
    assign out_pix = '{active: win_active, on: grid_on || label_on};

endmodule

`default_nettype wire

//--- tb/graph_overlay_sva.sv
`default_nettype none
`timescale 1ns/10ps

module graph_overlay_sva
    import graph_pkg::*;
(
    input logic CK,
    input logic rst_n,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input pix_s out_pix
);

    // a stalled output item holds until it is taken
    property hold_while_stalled;
        @(posedge CK) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pix);
    endproperty

    property ready_is_advance;
        @(posedge CK) disable iff (!rst_n)
        in_ready == (!out_valid || out_ready);   // output stage empty or drained
    endproperty

    property quiet_in_reset;
        @(posedge CK) !rst_n |=> !out_valid;
    endproperty

    assert property (hold_while_stalled) else $error("output item changed during a stall");
    assert property (ready_is_advance) else $error("in_ready differs from pipeline advance");
    assert property (quiet_in_reset) else $error("out_valid high while in reset");

endmodule

bind graph_overlay graph_overlay_sva u_graph_overlay_sva (
    .CK        (CK),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pix   (out_pix)
);

`default_nettype wire

//--- tb/graph_overlay_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "graph_config.svh"

module graph_overlay_tb
    import graph_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic CK;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    pos_s in_pos;
    logic out_valid;
    logic out_ready;
    pix_s out_pix;

    int          seed = 32'h55d6;
    logic        bp_mode;
    logic [41:0] font_tab [10];   // 7 rows of 6 pixels with scanline 0 on top
    pix_s        exp_q [$];
    pos_s        sent_q [$];
    int          n_sent;
    int          n_recv;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          n_failed_tests;
    int          test_errors;
    string       test_name;

    graph_overlay u_graph_overlay (
        .CK        (CK),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pos    (in_pos),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pix   (out_pix)
    );

    initial begin
        CK = 1'b0;
        forever #5 CK = ~CK;
    end

    // sink side stalls at random only while bp_mode is set
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge CK);
            #1;
            out_ready = bp_mode ? 1'($random(seed) & 1) : 1'b1;
        end
    end

    // outputs are stable at the falling edge and the transfer follows at the next rise
    always @(negedge CK) begin : monitor
        pix_s exp_pix;
        pos_s p;
        if (rst_n && out_valid && out_ready) begin
            n_recv++;
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("ERROR at %0t: output item arrived with none outstanding", $time);
            end else begin
                exp_pix = exp_q.pop_front();
                p       = sent_q.pop_front();
                check_val($sformatf("out_pix.on h=%0d v=%0d", p.h, p.v),
                          32'(out_pix.on), 32'(exp_pix.on));
                check_val($sformatf("out_pix.active h=%0d v=%0d", p.h, p.v),
                          32'(out_pix.active), 32'(exp_pix.active));
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = n_errors;
        n_tests++;
    endtask

    task automatic finish_test();
        if (n_errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            n_failed_tests++;
            $display("test %s: %0d errors", test_name, n_errors - test_errors);
        end
    endtask

    task automatic load_font();
        font_tab[0] = {6'b001110, 6'b010001, 6'b010011, 6'b010101,
                       6'b011001, 6'b010001, 6'b001110};
        font_tab[1] = {6'b000100, 6'b001100, 6'b000100, 6'b000100,
                       6'b000100, 6'b000100, 6'b001110};
        font_tab[2] = {6'b001110, 6'b010001, 6'b000001, 6'b000010,
                       6'b000100, 6'b001000, 6'b011111};
        font_tab[3] = {6'b001110, 6'b010001, 6'b000001, 6'b000110,
                       6'b000001, 6'b011001, 6'b001111};
        font_tab[4] = {6'b000010, 6'b000110, 6'b001010, 6'b010010,
                       6'b011111, 6'b000010, 6'b000010};
        font_tab[5] = {6'b011111, 6'b010000, 6'b010000, 6'b011110,
                       6'b000001, 6'b000001, 6'b011110};
        font_tab[6] = {6'b000011, 6'b000100, 6'b001000, 6'b011110,
                       6'b010001, 6'b010001, 6'b001110};
        font_tab[7] = {6'b011111, 6'b010001, 6'b000001, 6'b000010,
                       6'b000100, 6'b001000, 6'b010000};
        font_tab[8] = {6'b001110, 6'b010001, 6'b010001, 6'b011110,
                       6'b010001, 6'b010001, 6'b001110};
        font_tab[9] = {6'b001110, 6'b010001, 6'b010001, 6'b001111,
                       6'b000010, 6'b000100, 6'b011000};
    endtask

    // character code at label row r and column c or 15 for a blank
    function automatic int label_char(int r, int c);
        int value;
        int weight;
        value  = 2200 - 200 * r;
        weight = 1;
        for (int i = c; i < 3; i++) begin
            weight = weight * 10;
        end
        if (c < 3 && value < weight) return 15;   // leading zero
        return (value / weight) % 10;
    endfunction

    function automatic logic model_label(int h, int v);
        int         ref_v;
        int         start;
        int         x;
        int         code;
        logic [5:0] bit_idx;
        logic       lit;
        lit = 1'b0;
        x   = h / 2;
        for (int r = 0; r < `LABEL_ROWS; r++) begin
            ref_v = `GRAPH_LINES - `GRID_PITCH * (`LABEL_ROWS - 1 - r);
            start = ref_v - 16;
            if (v >= start && v <= ref_v - 3 && x < 24) begin
                code = label_char(r, x / 6);
                if (code != 15) begin
                    bit_idx = 6'((6 - (v - start) / 2) * 6 + 5 - x % 6);
                    lit     = font_tab[4'(code)][bit_idx];
                end
            end
        end
        return lit;
    endfunction

    function automatic pix_s model_pix(int h, int v);
        pix_s p;
        logic line;
        line     = (v % 40 == 0 && v >= 40 && v <= 440) || v == 479;
        p.active = v < `GRAPH_LINES && h >= `WIN_H_FIRST && h <= `WIN_H_LAST;
        p.on     = (line && (h & 4) != 0) || model_label(h, v);
        return p;
    endfunction

    // called and returns just after a rising edge with in_valid left high
    task automatic send_pos(input int h, input int v);
        int   waited;
        logic accepted;
        in_pos.h = hpos_t'(h);
        in_pos.v = vpos_t'(v);
        in_valid = 1'b1;
        exp_q.push_back(model_pix(h, v));
        sent_q.push_back(in_pos);
        n_sent++;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted) begin
            @(negedge CK);
            accepted = in_ready;
            @(posedge CK);
            #1;
            waited++;
            if (!accepted && waited >= WAIT_LIMIT) abort_run("in_ready");
        end
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge CK);
        #1;
    endtask

    task automatic drain();
        int waited;
        in_valid = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0) begin
            @(posedge CK);
            #1;
            waited++;
            if (waited >= WAIT_LIMIT) abort_run("outstanding output items");
        end
    endtask

    task automatic set_backpressure(input logic on);
        @(negedge CK);
        bp_mode = on;
        @(posedge CK);
        #1;
    endtask

    task automatic test_reset_latency();
        int   edges;
        logic seen;
        start_test("reset and latency");
        @(negedge CK);
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("in_ready", 32'(in_ready), 32'd1);
        @(posedge CK);
        #1;
        send_pos(100, 40);
        in_valid = 1'b0;
        edges    = 1;   // the accepting edge
        seen     = 1'b0;
        while (!seen) begin
            @(negedge CK);
            seen = out_valid;
            if (!seen) begin
                @(posedge CK);
                #1;
                edges++;
                if (edges > 20) abort_run("out_valid after one item");
            end
        end
        check_val("edges until out_valid", 32'(edges), 32'd3);
        drain();
        finish_test();
    endtask

    task automatic test_window();
        int hs [4] = '{32, 33, 800, 801};
        int vs [3] = '{0, 479, 480};
        start_test("plot window");
        foreach (vs[j]) begin
            foreach (hs[i]) begin
                send_pos(hs[i], vs[j]);
            end
        end
        drain();
        finish_test();
    endtask

    task automatic test_grid();
        start_test("grid lines");
        for (int v = 40; v <= 480; v += 40) begin
            for (int h = 0; h < 1024; h++) begin
                send_pos(h, v == 480 ? 479 : v);
            end
        end
        for (int h = 0; h < 1024; h++) begin
            send_pos(h, 100);   // between bands and off every line
        end
        drain();
        finish_test();
    endtask

    task automatic test_labels();
        int start;
        start_test("axis labels");
        for (int r = 0; r < `LABEL_ROWS; r++) begin
            start = `GRAPH_LINES - `GRID_PITCH * (`LABEL_ROWS - 1 - r) - 16;
            for (int v = start - 1; v <= start + 14; v++) begin
                for (int h = 0; h < 52; h++) begin
                    send_pos(h, v);
                end
            end
        end
        drain();
        finish_test();
    endtask

    task automatic test_backpressure();
        int   hs [$];
        int   vs [$];
        logic gaps [$];
        int   r;
        int   sent0;
        int   recv0;
        start_test("random back-pressure");
        for (int i = 0; i < 3000; i++) begin
            r = $random(seed);
            hs.push_back(r[10] ? (r & 63) : (r & 1023));
            vs.push_back(r[20] ? ((r >> 11) & 63) : ((r >> 11) & 511));
            gaps.push_back(r[30] && r[29]);
        end
        sent0 = n_sent;
        recv0 = n_recv;
        set_backpressure(1'b1);
        foreach (hs[i]) begin
            if (gaps[i]) idle_cycle();
            send_pos(hs[i], vs[i]);
        end
        drain();
        set_backpressure(1'b0);
        repeat (4) idle_cycle();   // no item may leave the emptied pipe
        check_val("items out", 32'(n_recv - recv0), 32'(n_sent - sent0));
        finish_test();
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pos   = '0;
        bp_mode  = 1'b0;
        load_font();
        repeat (8) @(posedge CK);
        #1;
        rst_n = 1'b1;

        test_reset_latency();
        test_window();
        test_grid();
        test_labels();
        test_backpressure();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 n_tests, n_failed_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/graph_pkg.sv
hdl/label_locator.sv
hdl/label_text.sv
hdl/grid_ruler.sv
hdl/graph_overlay.sv
tb/graph_overlay_sva.sv
tb/graph_overlay_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module graph_overlay_tb -f tb.f -o graph_overlay_sim

# the run's own exit status is ignored here, the log decides
./obj_dir/graph_overlay_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1
